//--- Makefile
# Verilator build and run of the lane operand queue testbench

VERILATOR ?= verilator
TOP       ?= operand_queue_tb
FILELIST  ?= operand_queue.f
MDIR      ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

# The log decides the result, so a missing pass line fails the target
run: compile
	./$(MDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)

//--- bench/operand_queue_tb.sv
// Testbench of the lane operand queue
// LCG driven commands, words and ready gaps with a queue based reference model
// Assertions check the consumed words, the target unit, output hold and credits

`timescale 1ns/1ps

module operand_queue_tb;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  opq_cmd_pkg::opq_cmd_t   cmd_i;
  logic                    cmd_valid_i;
  opq_elem_pkg::elen_t     operand_i;
  logic                    operand_valid_i;
  logic                    operand_issued_i;
  logic                    operand_queue_ready_o;
  opq_elem_pkg::elen_t     operand_o;
  opq_cmd_pkg::target_fu_e target_fu_o;
  logic                    operand_valid_o;
  logic                    operand_ready_i = 1'b0;

  // Consumer enable that only changes right after a rising edge
  logic        ready_en  = 1'b0;
  // Separate LCG states for the stimulus and the consumer
  logic [31:0] data_rnd  = 32'hf900;
  logic [31:0] ready_rnd = 32'hf900;

  // Reference model queues
  opq_elem_pkg::elen_t     src_words[$];
  opq_elem_pkg::elen_t     exp_word_q[$];
  opq_cmd_pkg::target_fu_e exp_fu_q[$];

  // Output seen at the last edge for the hold check
  logic                    stall_q = 1'b0;
  opq_elem_pkg::elen_t     held_word_q;
  opq_cmd_pkg::target_fu_e held_fu_q;

  operand_queue dut_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .cmd_i                 (cmd_i),
    .cmd_valid_i           (cmd_valid_i),
    .operand_i             (operand_i),
    .operand_valid_i       (operand_valid_i),
    .operand_issued_i      (operand_issued_i),
    .operand_queue_ready_o (operand_queue_ready_o),
    .operand_o             (operand_o),
    .target_fu_o           (target_fu_o),
    .operand_valid_o       (operand_valid_o),
    .operand_ready_i       (operand_ready_i)
  );

  always #2 clk_i = ~clk_i;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Widening factor as a power of two
  function automatic int widen_log2(input opq_cmd_pkg::conv_e conv);
    case (conv)
      opq_cmd_pkg::ConvSExt2, opq_cmd_pkg::ConvZExt2: return 1;
      opq_cmd_pkg::ConvSExt4, opq_cmd_pkg::ConvZExt4: return 2;
      opq_cmd_pkg::ConvSExt8, opq_cmd_pkg::ConvZExt8: return 3;
      default: return 0;
    endcase
  endfunction

  function automatic bit is_sign_ext(input opq_cmd_pkg::conv_e conv);
    return (conv == opq_cmd_pkg::ConvSExt2) || (conv == opq_cmd_pkg::ConvSExt4) ||
           (conv == opq_cmd_pkg::ConvSExt8);
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Walks the source words slice by slice and queues every output word
  task automatic predict_outputs(input opq_cmd_pkg::opq_cmd_t cmd);
    int          w;
    int          k;
    int          epw;
    int          sel;
    int          cnt;
    int          widx;
    int          e;
    bit          done;
    logic [63:0] elem;
    logic [63:0] out;
    logic [63:0] src_mask;
    logic [63:0] dst_mask;
    w        = 1 << int'(cmd.eew);
    k        = 1 << widen_log2(cmd.conv);
    // Elements per output word
    epw      = 8 / (k * w);
    src_mask = {64{1'b1}} >> (64 - 8 * w);
    dst_mask = {64{1'b1}} >> (64 - 8 * k * w);
    sel      = 0;
    cnt      = 0;
    widx     = 0;
    done     = 1'b0;
    while (!done) begin
      out = '0;
      for (e = 0; e < epw; e++) begin
        elem = (src_words[widx] >> (8 * (sel + e * w))) & src_mask;
        if (is_sign_ext(cmd.conv) && elem[8*w-1]) begin
          elem = elem | ~src_mask;
        end
        out = out | ((elem & dst_mask) << (8 * k * w * e));
      end
      exp_word_q.push_back(out);
      exp_fu_q.push_back(cmd.target_fu);
      cnt = cnt + epw;
      // End of the vector length drops the rest of the word
      if (cnt >= int'(cmd.vl)) begin
        done = 1'b1;
      end else begin
        sel = (sel + 8 / k) % 8;
        if (sel == 0) begin
          widx++;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers entered on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic load_words(input int count);
    opq_elem_pkg::elen_t word;
    src_words.delete();
    repeat (count) begin
      data_rnd    = lcg_next(data_rnd);
      word[63:32] = data_rnd;
      data_rnd    = lcg_next(data_rnd);
      word[31:0]  = data_rnd;
      src_words.push_back(word);
    end
  endtask

  task automatic push_command(input opq_cmd_pkg::opq_cmd_t cmd);
    cmd_i       = cmd;
    cmd_valid_i = 1'b1;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic wait_for_credit();
    int n;
    n = 0;
    while (!operand_queue_ready_o && n < 500) begin
      @(negedge clk_i);
      n++;
    end
    if (!operand_queue_ready_o) begin
      report_error("timeout waiting for operand_queue_ready_o to rise");
    end
  endtask

  // One register file read answered one cycle after its issue
  task automatic send_word(input opq_elem_pkg::elen_t word);
    wait_for_credit();
    operand_issued_i = 1'b1;
    @(negedge clk_i);
    operand_issued_i = 1'b0;
    operand_i        = word;
    operand_valid_i  = 1'b1;
    @(negedge clk_i);
    operand_valid_i  = 1'b0;
  endtask

  task automatic wait_for_drain();
    int n;
    n = 0;
    while (exp_word_q.size() != 0 && n < 2000) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_word_q.size() != 0) begin
      report_error("timeout waiting for the predicted words to be consumed");
    end
  endtask

  task automatic run_command(input opq_cmd_pkg::conv_e conv, input opq_elem_pkg::eew_e eew,
                             input int vl, input opq_cmd_pkg::target_fu_e fu);
    opq_cmd_pkg::opq_cmd_t cmd;
    int                    nwords;
    int                    i;
    cmd.conv      = conv;
    cmd.eew       = eew;
    cmd.vl        = opq_elem_pkg::vlen_t'(vl);
    cmd.target_fu = fu;
    // Source words needed for vl elements of the source width
    nwords        = (vl * (1 << int'(eew)) + 7) / 8;
    load_words(nwords);
    predict_outputs(cmd);
    push_command(cmd);
    for (i = 0; i < nwords; i++) begin
      send_word(src_words[i]);
    end
    wait_for_drain();
  endtask

  ////////////////////////////////////////////////////////////
  // Consumer and checks
  ////////////////////////////////////////////////////////////

  // Random low phases of the functional unit ready
  always @(negedge clk_i) begin
    ready_rnd       = lcg_next(ready_rnd);
    operand_ready_i = ready_en && (ready_rnd[31:30] != 2'b00);
  end

  // Valid output stays up until it is consumed
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (operand_valid_o && !operand_ready_i) |=> operand_valid_o)
    else report_error("operand_valid_o dropped before its word was consumed");

  always @(posedge clk_i) begin
    // Stalled output holds its word and target unit
    if (rst_ni && stall_q) begin
      assert (operand_o == held_word_q)
        else report_error($sformatf("mismatch operand_o held %h now %h", held_word_q, operand_o));
      assert (target_fu_o == held_fu_q)
        else report_error($sformatf("mismatch target_fu_o held %h now %h", held_fu_q,
                                    target_fu_o));
    end
    // Consumed word against the model
    if (rst_ni && operand_valid_o && operand_ready_i) begin
      assert (exp_word_q.size() != 0)
        else report_error("a word was consumed while the model expected none");
      assert (operand_o == exp_word_q[0])
        else report_error($sformatf("mismatch operand_o exp %h got %h", exp_word_q[0], operand_o));
      assert (target_fu_o == exp_fu_q[0])
        else report_error($sformatf("mismatch target_fu_o exp %h got %h", exp_fu_q[0],
                                    target_fu_o));
      void'(exp_word_q.pop_front());
      void'(exp_fu_q.pop_front());
    end
    stall_q     <= rst_ni && operand_valid_o && !operand_ready_i;
    held_word_q <= operand_o;
    held_fu_q   <= target_fu_o;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    opq_cmd_pkg::opq_cmd_t cmd;
    int                    round;
    int                    c;
    int                    e;
    int                    vl;
    rst_ni           = 1'b0;
    cmd_i            = '0;
    cmd_valid_i      = 1'b0;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Idle outputs after reset
    assert (!operand_valid_o)
      else report_error($sformatf("mismatch operand_valid_o exp 0 got %h", operand_valid_o));
    assert (operand_queue_ready_o)
      else report_error($sformatf("mismatch operand_queue_ready_o exp 1 got %h",
                                  operand_queue_ready_o));

    // Two reads with the consumer held off use up every credit
    cmd.conv      = opq_cmd_pkg::ConvNone;
    cmd.eew       = opq_elem_pkg::EW64;
    cmd.vl        = opq_elem_pkg::vlen_t'(2);
    cmd.target_fu = opq_cmd_pkg::FuMfpuAddrgen;
    load_words(2);
    predict_outputs(cmd);
    push_command(cmd);
    operand_issued_i = 1'b1;
    @(negedge clk_i);
    operand_i        = src_words[0];
    operand_valid_i  = 1'b1;
    @(negedge clk_i);
    operand_issued_i = 1'b0;
    operand_i        = src_words[1];
    @(negedge clk_i);
    operand_valid_i  = 1'b0;
    assert (!operand_queue_ready_o)
      else report_error($sformatf("mismatch operand_queue_ready_o exp 0 got %h",
                                  operand_queue_ready_o));
    // First pop gives a credit back
    @(posedge clk_i);
    ready_en = 1'b1;
    @(negedge clk_i);
    wait_for_credit();
    // Exactly one word has left the buffer when ready returns
    assert (exp_word_q.size() == 1)
      else report_error("operand_queue_ready_o did not return high after exactly one word pop");
    wait_for_drain();

    // Short zero widened commands end inside a word
    run_command(opq_cmd_pkg::ConvZExt2, opq_elem_pkg::EW8, 5, opq_cmd_pkg::FuAluSldu);
    run_command(opq_cmd_pkg::ConvZExt4, opq_elem_pkg::EW16, 3, opq_cmd_pkg::FuMfpuAddrgen);
    run_command(opq_cmd_pkg::ConvZExt8, opq_elem_pkg::EW8, 11, opq_cmd_pkg::FuAluSldu);

    // Every legal conversion and width with random vl and target unit
    for (round = 0; round < 3; round++) begin
      for (c = 0; c < 7; c++) begin
        for (e = 0; e < 4; e++) begin
          if (widen_log2(opq_cmd_pkg::conv_e'(c)) + e <= 3) begin
            data_rnd = lcg_next(data_rnd);
            vl       = 1 + int'(data_rnd[31:16]) % 40;
            run_command(opq_cmd_pkg::conv_e'(c), opq_elem_pkg::eew_e'(e), vl,
                        opq_cmd_pkg::target_fu_e'(data_rnd[15]));
          end
        end
      end
    end

    repeat (4) @(negedge clk_i);
    // Every word consumed and every credit returned
    if (operand_valid_o || !operand_queue_ready_o) begin
      report_error("operand queue not idle at the end of the run");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

//--- common/opq_cmd_pkg.sv
// Command level definitions for the lane operand queue
// Conversion and target unit encodings, the command struct,
// buffer depths and small conversion decode helpers

package opq_cmd_pkg;

  // Depth of the command buffer
  localparam int unsigned CmdBufDepth  = 2;
  // Depth of the operand word buffer, also the number of read credits
  localparam int unsigned DataBufDepth = 2;

  // Integer conversion applied to the source word
  typedef enum logic [2:0] {
    ConvNone,
    ConvSExt2,
    ConvSExt4,
    ConvSExt8,
    ConvZExt2,
    ConvZExt4,
    ConvZExt8
  } conv_e;

  // Functional unit that consumes the operand
  typedef enum logic {
    FuAluSldu,
    FuMfpuAddrgen
  } target_fu_e;

  // Command from the operand requester
  typedef struct packed {
    conv_e                 conv;
    opq_elem_pkg::eew_e    eew;
    opq_elem_pkg::vlen_t   vl;
    target_fu_e            target_fu;
  } opq_cmd_t;

  // log2 of the widening factor
  function automatic logic [1:0] conv_shift(conv_e conv);
    case (conv)
      ConvSExt2, ConvZExt2: conv_shift = 2'd1;
      ConvSExt4, ConvZExt4: conv_shift = 2'd2;
      ConvSExt8, ConvZExt8: conv_shift = 2'd3;
      default:              conv_shift = 2'd0;
    endcase
  endfunction

  // Sign extension instead of zero extension
  function automatic logic conv_signed(conv_e conv);
    conv_signed = (conv == ConvSExt2) || (conv == ConvSExt4) || (conv == ConvSExt8);
  endfunction

endpackage

//--- common/opq_elem_pkg.sv
// Element level definitions for the lane operand queue
// Operand word, byte and vector length widths
// Element width encoding and the word, count and byte-select types

package opq_elem_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // One operand word as read from the register file
  localparam int unsigned ElenBits  = 64;
  // Bytes per operand word
  localparam int unsigned ElenBytes = ElenBits / 8;
  // Vector length and element count width
  localparam int unsigned VlBits    = 16;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // Operand word
  typedef logic [ElenBits-1:0] elen_t;
  // Element count or vector length
  typedef logic [VlBits-1:0] vlen_t;
  // Byte offset of the current source slice inside a word
  typedef logic [$clog2(ElenBytes)-1:0] sel_t;

  // Source element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } eew_e;

endpackage

//--- operand_queue.f
common/opq_elem_pkg.sv
common/opq_cmd_pkg.sv
source/sync_fifo.sv
source/operand_credit.sv
operand_queue/operand_extender.sv
operand_queue/element_tracker.sv
operand_queue/operand_queue.sv
bench/operand_queue_tb.sv

//--- operand_queue/element_tracker.sv
// Element tracker of the operand queue
// Byte select and element count registers
// Word pop and command pop decisions for each consumed output word

`timescale 1ns/1ps

module element_tracker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  opq_cmd_pkg::opq_cmd_t cmd_i,
  input  logic                  word_valid_i,
  input  logic                  ready_i,
  output opq_elem_pkg::sel_t    select_o,
  output logic                  word_pop_o,
  output logic                  cmd_pop_o
);

  // Conversion decode
  logic [1:0]                      ext_shift;
  logic [2:0]                      wide_shift;
  // Elements produced per output word, 8/(k*w)
  opq_elem_pkg::vlen_t             elem_step;
  // Select and count sums, with carry and overflow bits
  logic [3:0]                      sel_sum;
  logic [opq_elem_pkg::VlBits:0]   count_sum;
  logic                            consume;
  logic                            last_elem;

  opq_elem_pkg::sel_t  select_d, select_q;
  opq_elem_pkg::vlen_t count_d, count_q;

  always_comb begin
    ext_shift  = opq_cmd_pkg::conv_shift(cmd_i.conv);
    wide_shift = {1'b0, cmd_i.eew} + {1'b0, ext_shift};
    // Widening past 64 bits is outside the contract, count one element then
    elem_step  = (wide_shift > 3'd3) ? opq_elem_pkg::vlen_t'(1)
                                     : opq_elem_pkg::vlen_t'(8) >> wide_shift;
    // Select advances by 8/k bytes, the carry marks a wrap
    sel_sum    = {1'b0, select_q} + (4'd8 >> ext_shift);
    count_sum  = {1'b0, count_q} + {1'b0, elem_step};
    last_elem  = (count_sum >= {1'b0, cmd_i.vl});
    consume    = word_valid_i && ready_i;

    select_d   = select_q;
    count_d    = count_q;
    word_pop_o = 1'b0;
    cmd_pop_o  = 1'b0;

    if (consume) begin
      select_d   = sel_sum[2:0];
      count_d    = count_sum[opq_elem_pkg::VlBits-1:0];
      // ConvNone steps by a full word, so it wraps on every consumption
      word_pop_o = sel_sum[3];
      // End of command drops the rest of the word as well
      if (last_elem) begin
        word_pop_o = 1'b1;
        cmd_pop_o  = 1'b1;
        select_d   = '0;
        count_d    = '0;
      end
    end
  end

  assign select_o = select_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      select_q <= '0;
      count_q  <= '0;
    end else begin
      select_q <= select_d;
      count_q  <= count_d;
    end
  end

endmodule

//--- operand_queue/operand_extender.sv
// Integer widening of the current source slice
// Sign or zero extension by 2, 4 and 8 of elements taken at the byte select
// Pure combinational, words pass unchanged without a conversion

`timescale 1ns/1ps

module operand_extender (
  input  opq_cmd_pkg::opq_cmd_t cmd_i,
  input  opq_elem_pkg::sel_t    select_i,
  input  opq_elem_pkg::elen_t   word_i,
  output opq_elem_pkg::elen_t   word_o
);

  // Byte views of the source and the result
  logic [opq_elem_pkg::ElenBytes-1:0][7:0] src_bytes;
  logic [opq_elem_pkg::ElenBytes-1:0][7:0] out_bytes;

  // Conversion decode
  logic [1:0] ext_shift;
  logic       is_signed;
  // log2 of the output element size in bytes
  logic [2:0] wide_shift;

  // Per output byte bookkeeping
  opq_elem_pkg::sel_t elem_idx;
  opq_elem_pkg::sel_t byte_idx;
  opq_elem_pkg::sel_t src_lsb;
  opq_elem_pkg::sel_t src_msb;
  opq_elem_pkg::sel_t src_idx;
  logic               sign_bit;

  always_comb begin
    src_bytes  = word_i;
    ext_shift  = opq_cmd_pkg::conv_shift(cmd_i.conv);
    is_signed  = opq_cmd_pkg::conv_signed(cmd_i.conv);
    wide_shift = {1'b0, cmd_i.eew} + {1'b0, ext_shift};

    // Plain pass through by default
    out_bytes = src_bytes;
    elem_idx  = '0;
    byte_idx  = '0;
    src_lsb   = '0;
    src_msb   = '0;
    src_idx   = '0;
    sign_bit  = 1'b0;

    if (cmd_i.conv != opq_cmd_pkg::ConvNone) begin
      ////////////////////////////////////////////////////////
      // Build the result byte by byte
      ////////////////////////////////////////////////////////
      for (int b = 0; b < opq_elem_pkg::ElenBytes; b++) begin
        // Output element this byte belongs to and its byte offset inside it
        elem_idx = 3'(b >> wide_shift);
        byte_idx = 3'(b) & 3'((1 << wide_shift) - 1);

        // Source element starts at select plus e*w bytes
        src_lsb  = select_i + 3'(elem_idx << cmd_i.eew);
        src_msb  = src_lsb + 3'((1 << cmd_i.eew) - 1);
        src_idx  = src_lsb + byte_idx;

        // Extension fill comes from the top bit of the source element
        sign_bit = is_signed & src_bytes[src_msb][7];

        if ({1'b0, byte_idx} < (4'd1 << cmd_i.eew)) begin
          // Low bytes copy the source element
          out_bytes[b] = src_bytes[src_idx];
        end else begin
          // Upper bytes carry the sign or zero fill
          out_bytes[b] = {8{sign_bit}};
        end
      end
    end

    word_o = out_bytes;
  end

endmodule

//--- operand_queue/operand_queue.sv
// Operand queue of one vector lane
// Command and word buffers, read credit counter,
// element tracker and integer widening stage

`timescale 1ns/1ps

module operand_queue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Operand requester side
  input  opq_cmd_pkg::opq_cmd_t   cmd_i,
  input  logic                    cmd_valid_i,
  // Register file side
  input  opq_elem_pkg::elen_t     operand_i,
  input  logic                    operand_valid_i,
  input  logic                    operand_issued_i,
  output logic                    operand_queue_ready_o,
  // Functional unit side
  output opq_elem_pkg::elen_t     operand_o,
  output opq_cmd_pkg::target_fu_e target_fu_o,
  output logic                    operand_valid_o,
  input  logic                    operand_ready_i
);

  opq_cmd_pkg::opq_cmd_t cmd;
  logic                  cmd_pop;
  opq_elem_pkg::elen_t   word;
  logic                  word_pop;
  opq_elem_pkg::sel_t    select;

  ////////////////////////////////////////////////////////////
  // Buffers
  ////////////////////////////////////////////////////////////

  // Commands arrive ahead of their words, so the head is always valid when used
  sync_fifo #(
    .Width ($bits(opq_cmd_pkg::opq_cmd_t)),
    .Depth (opq_cmd_pkg::CmdBufDepth)
  ) cmd_buf_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_valid_i),
    .data_i  (cmd_i),
    .pop_i   (cmd_pop),
    .data_o  (cmd),
    .valid_o ()
  );

  // Word buffer, its occupancy is the output valid
  sync_fifo #(
    .Width (opq_elem_pkg::ElenBits),
    .Depth (opq_cmd_pkg::DataBufDepth)
  ) word_buf_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (operand_valid_i),
    .data_i  (operand_i),
    .pop_i   (word_pop),
    .data_o  (word),
    .valid_o (operand_valid_o)
  );

  operand_credit credit_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .issued_i (operand_issued_i),
    .pop_i    (word_pop),
    .ready_o  (operand_queue_ready_o)
  );

  ////////////////////////////////////////////////////////////
  // Tracking and widening
  ////////////////////////////////////////////////////////////

  element_tracker tracker_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd),
    .word_valid_i (operand_valid_o),
    .ready_i      (operand_ready_i),
    .select_o     (select),
    .word_pop_o   (word_pop),
    .cmd_pop_o    (cmd_pop)
  );

  operand_extender extender_i (
    .cmd_i    (cmd),
    .select_i (select),
    .word_i   (word),
    .word_o   (operand_o)
  );

  // Target unit echoed from the head command
  assign target_fu_o = cmd.target_fu;

endmodule

//--- source/operand_credit.sv
// Read credit counter of the operand word buffer
// Counts reads in flight plus words held in the buffer
// Ready drops once every buffer slot is spoken for

`timescale 1ns/1ps

module operand_credit (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic issued_i,
  input  logic pop_i,
  output logic ready_o
);

  localparam int unsigned CntBits = $clog2(opq_cmd_pkg::DataBufDepth + 1);

  logic [CntBits-1:0] used_d, used_q;

  always_comb begin
    used_d = used_q;
    // New read on its way from the register file
    if (issued_i) begin
      used_d = used_d + 1'b1;
    end
    // Word left the buffer and frees its slot
    if (pop_i) begin
      used_d = used_d - 1'b1;
    end
  end

  // Registered count, so ready reacts one cycle after an issue or pop
  assign ready_o = (used_q < CntBits'(opq_cmd_pkg::DataBufDepth));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q <= '0;
    end else begin
      used_q <= used_d;
    end
  end

endmodule

//--- source/sync_fifo.sv
// Generic registered FIFO
// Register array with read and write pointers and a fill count
// Head entry on data_o, not empty flag on valid_o

`timescale 1ns/1ps

module sync_fifo #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [Width-1:0] data_i,
  input  logic             pop_i,
  output logic [Width-1:0] data_o,
  output logic             valid_o
);

  // Pointer and fill count widths
  localparam int unsigned PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntBits = $clog2(Depth + 1);

  logic [Width-1:0]   mem_q [Depth];
  logic [PtrBits-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntBits-1:0] count_q;
  logic               do_push, do_pop;

  // Writes into a full FIFO and reads from an empty one are dropped
  assign do_push = push_i && (count_q != CntBits'(Depth));
  assign do_pop  = pop_i && (count_q != '0);

  assign data_o  = mem_q[rd_ptr_q];
  assign valid_o = (count_q != '0);

  ////////////////////////////////////////////////////////////
  // Pointers and fill count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        // Wrap at Depth, which need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PtrBits'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrBits'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule
